// ==== verilog/lsu_pkg.sv ====
/*
  shared widths, access-size encoding and byte offset type for the load/store unit
  every lsu module pulls these in by wildcard import in its header
*/

package lsu_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int ADDR_W   = 32;  // data memory address
  localparam int DATA_W   = 32;  // data word
  localparam int BE_W     = 4;   // one enable per byte lane
  localparam int OFFSET_W = 2;   // byte offset within a word

  //////////////////////////////
  // access size
  //////////////////////////////

  // 2-bit size code from the decoder, value 3 behaves as a byte
  typedef logic [1:0] data_type_t;

  localparam data_type_t TYPE_WORD = 2'd0;
  localparam data_type_t TYPE_HALF = 2'd1;
  localparam data_type_t TYPE_BYTE = 2'd2;

  // byte position inside a 32-bit word
  typedef logic [OFFSET_W-1:0] byte_off_t;

endpackage

// ==== verilog/lsu_addr_gen.sv ====
/*
  effective address for loads and stores, plus detection of accesses that
  cross a word boundary and so need a second memory access
*/

`timescale 1ns/1ns

module lsu_addr_gen import lsu_pkg::*;
(
  input  logic [ADDR_W-1:0] operand_a_i,
  input  logic [ADDR_W-1:0] operand_b_i,
  input  logic              addr_useincr_i,       // a + b when set, else a alone
  input  logic              data_req_i,
  input  data_type_t        data_type_i,
  input  logic              data_misaligned_ex_i, // second part in flight
  output logic [ADDR_W-1:0] data_addr_o,
  output byte_off_t         addr_off_o,
  output logic              data_misaligned_o     // to controller, stalls for part two
);

  assign data_addr_o = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_off_o  = data_addr_o[OFFSET_W-1:0];  // low bits pick the byte lane

  // only a first part can be misaligned, the second is always at lane 0
  always_comb
  begin
    data_misaligned_o = 1'b0;
    if (data_req_i && !data_misaligned_ex_i)
    begin
      if (data_type_i == TYPE_WORD)
        data_misaligned_o = (addr_off_o != 2'd0);   // any offset spills
      else if (data_type_i == TYPE_HALF)
        data_misaligned_o = (addr_off_o == 2'd3);   // top lane only
    end
  end

endmodule

// ==== verilog/lsu_store_align.sv ====
/*
  byte enables and store data placement for the data memory port
  purely combinational, fed by the address generator and the execute stage
*/

`timescale 1ns/1ns

module lsu_store_align import lsu_pkg::*;
(
  input  data_type_t        data_type_i,
  input  byte_off_t         addr_off_i,      // lane of the first byte in memory
  input  byte_off_t         reg_off_i,       // lane of that byte in the source register
  input  logic              misaligned_st_i, // high during a second part
  input  logic [DATA_W-1:0] wdata_i,
  output logic [BE_W-1:0]   data_be_o,
  output logic [DATA_W-1:0] data_wdata_o
);

  byte_off_t rot;  // left rotation in bytes

  //////////////////////////////
  // byte enables
  //////////////////////////////

  always_comb
  begin
    case (data_type_i)
      TYPE_WORD:
      begin
        if (!misaligned_st_i)
          data_be_o = {BE_W{1'b1}} << addr_off_i;        // offset lane and above
        else
          data_be_o = ~({BE_W{1'b1}} << addr_off_i);     // spill lanes below offset
      end
      TYPE_HALF:
      begin
        if (!misaligned_st_i)
          data_be_o = BE_W'(2'b11) << addr_off_i;        // lane 3 keeps only its top byte
        else
          data_be_o = BE_W'(1'b1);                       // remaining byte sits in lane 0
      end
      TYPE_BYTE, 2'd3:
        data_be_o = BE_W'(1'b1) << addr_off_i;
      default:
        data_be_o = '0;
    endcase
  end

  //////////////////////////////
  // lane rotation
  //////////////////////////////

  assign rot = addr_off_i - reg_off_i;  // wraps mod 4

  always_comb
  begin
    case (rot)
      2'd0:    data_wdata_o = wdata_i;
      2'd1:    data_wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'd2:    data_wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: data_wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

endmodule

// ==== verilog/lsu_load_align.sv ====
/*
  load side of the unit: remembers the granted access, aligns and extends the
  response, and joins the two halves of a split word or halfword
*/

`timescale 1ns/1ns

module lsu_load_align import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              data_gnt_i,       // capture strobe
  input  logic              data_we_i,
  input  data_type_t        data_type_i,
  input  byte_off_t         addr_off_i,
  input  logic              sign_ext_i,
  input  logic              data_rvalid_i,
  input  logic [DATA_W-1:0] data_rdata_i,
  input  logic              misaligned_ex_i,  // second part being issued
  input  logic              misaligned_o_i,   // first part of a split access
  output logic [DATA_W-1:0] data_rdata_ex_o
);

  data_type_t        type_q;
  byte_off_t         off_q;
  logic              sign_ext_q;
  logic              we_q;
  logic [DATA_W-1:0] rdata_q;   // first half of a split load, or last result

  logic [DATA_W-1:0] word_al;
  logic [15:0]       half_sel;
  logic [7:0]        byte_sel;
  logic [DATA_W-1:0] rdata_ext;

  // attributes of the access in flight, the response comes later
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q     <= TYPE_WORD;
      off_q      <= '0;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end
    else if (data_gnt_i)
    begin
      type_q     <= data_type_i;
      off_q      <= addr_off_i;
      sign_ext_q <= sign_ext_i;
      we_q       <= data_we_i;
    end
  end

  //////////////////////////////
  // alignment
  //////////////////////////////

  // split word: upper bytes of part one below low bytes of part two
  always_comb
  begin
    case (off_q)
      2'd0:    word_al = data_rdata_i;
      2'd1:    word_al = {data_rdata_i[7:0],  rdata_q[31:8]};
      2'd2:    word_al = {data_rdata_i[15:0], rdata_q[31:16]};
      default: word_al = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb
  begin
    case (off_q)
      2'd0:    half_sel = data_rdata_i[15:0];
      2'd1:    half_sel = data_rdata_i[23:8];
      2'd2:    half_sel = data_rdata_i[31:16];
      default: half_sel = {data_rdata_i[7:0], rdata_q[31:24]};  // split halfword
    endcase
  end

  assign byte_sel = data_rdata_i[{off_q, 3'b000} +: 8];

  // extension, replicated bit is zero unless signed
  always_comb
  begin
    case (type_q)
      TYPE_WORD: rdata_ext = word_al;
      TYPE_HALF: rdata_ext = {{(DATA_W-16){sign_ext_q & half_sel[15]}}, half_sel};
      default:   rdata_ext = {{(DATA_W-8){sign_ext_q & byte_sel[7]}}, byte_sel};
    endcase
  end

  // raw word kept while a split access is under way, final value otherwise
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (data_rvalid_i && !we_q)
    begin
      if (misaligned_ex_i || misaligned_o_i)
        rdata_q <= data_rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q;  // live in the rvalid cycle

endmodule

// ==== verilog/lsu_mem_ctrl.sv ====
/*
  request/response sequencing towards data memory
  keeps one access outstanding and holds off new requests while execute stalls
*/

`timescale 1ns/1ns

module lsu_mem_ctrl
(
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_ex_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic ex_valid_i,
  output logic data_req_o,
  output logic lsu_ready_ex_o,  // low while a request is not yet granted
  output logic lsu_ready_wb_o   // low while a response is pending
);

  typedef enum logic [1:0]
  {
    IDLE,
    WAIT_RVALID,
    WAIT_RVALID_EX_STALL,
    IDLE_EX_STALL
  } state_t;

  state_t state_q, state_d;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  //////////////////////////////
  // next state and outputs
  //////////////////////////////

  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      IDLE:
      begin
        data_req_o = data_req_ex_i;
        if (data_req_ex_i)
        begin
          lsu_ready_ex_o = data_gnt_i;  // stall execute until granted
          if (data_gnt_i)
            state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
        end
      end

      WAIT_RVALID:
      begin
        lsu_ready_wb_o = data_rvalid_i;
        if (data_rvalid_i)
        begin
          // response frees the port so the next request may go out now
          data_req_o = data_req_ex_i;
          if (data_req_ex_i)
          begin
            lsu_ready_ex_o = data_gnt_i;
            if (data_gnt_i)
              state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
            else
              state_d = IDLE;
          end
          else
            state_d = IDLE;
        end
        else
          lsu_ready_ex_o = !data_req_ex_i;  // next request held until the response
      end

      WAIT_RVALID_EX_STALL:
      begin
        // no new request here while the stalled instruction is still in execute
        if (data_rvalid_i)
          state_d = ex_valid_i ? IDLE : IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = WAIT_RVALID;  // stall gone so back to the normal wait
      end

      IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = IDLE;
      end

      default: state_d = IDLE;
    endcase
  end

endmodule

// ==== verilog/lsu_top.sv ====
/*
  load/store unit top: address generation, store alignment, load alignment and
  the memory controller, between the execute stage and the data memory port
*/

`timescale 1ns/1ns

module lsu_top import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  // execute stage
  input  logic              data_req_ex_i,
  input  logic              data_we_ex_i,
  input  data_type_t        data_type_ex_i,
  input  logic [DATA_W-1:0] data_wdata_ex_i,
  input  byte_off_t         data_reg_offset_ex_i,  // byte lane of store data in register
  input  logic              data_sign_ext_ex_i,
  input  logic [ADDR_W-1:0] operand_a_ex_i,
  input  logic [ADDR_W-1:0] operand_b_ex_i,
  input  logic              addr_useincr_ex_i,
  input  logic              data_misaligned_ex_i,  // second part of a split access
  input  logic              ex_valid_i,
  output logic [DATA_W-1:0] data_rdata_ex_o,
  output logic              data_misaligned_o,
  output logic              lsu_ready_ex_o,
  output logic              lsu_ready_wb_o,

  // data memory
  output logic              data_req_o,
  output logic [ADDR_W-1:0] data_addr_o,
  output logic              data_we_o,
  output logic [BE_W-1:0]   data_be_o,
  output logic [DATA_W-1:0] data_wdata_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  logic [DATA_W-1:0] data_rdata_i
);

  byte_off_t addr_off;  // shared by both align blocks

  assign data_we_o = data_we_ex_i;

  lsu_addr_gen i_addr_gen
  (
    .operand_a_i          (operand_a_ex_i),
    .operand_b_i          (operand_b_ex_i),
    .addr_useincr_i       (addr_useincr_ex_i),
    .data_req_i           (data_req_ex_i),
    .data_type_i          (data_type_ex_i),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_addr_o          (data_addr_o),
    .addr_off_o           (addr_off),
    .data_misaligned_o    (data_misaligned_o)
  );

  lsu_store_align i_store_align
  (
    .data_type_i     (data_type_ex_i),
    .addr_off_i      (addr_off),
    .reg_off_i       (data_reg_offset_ex_i),
    .misaligned_st_i (data_misaligned_ex_i),
    .wdata_i         (data_wdata_ex_i),
    .data_be_o       (data_be_o),
    .data_wdata_o    (data_wdata_o)
  );

  lsu_load_align i_load_align
  (
    .clk             (clk),
    .rst_n           (rst_n),
    .data_gnt_i      (data_gnt_i),
    .data_we_i       (data_we_ex_i),
    .data_type_i     (data_type_ex_i),
    .addr_off_i      (addr_off),
    .sign_ext_i      (data_sign_ext_ex_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_rdata_i    (data_rdata_i),
    .misaligned_ex_i (data_misaligned_ex_i),
    .misaligned_o_i  (data_misaligned_o),
    .data_rdata_ex_o (data_rdata_ex_o)
  );

  lsu_mem_ctrl i_mem_ctrl
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .ex_valid_i     (ex_valid_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o)
  );

endmodule

// ==== bench/lsu_tb.sv ====
/*
  directed testbench for the load/store unit top level
  a word-addressed memory model answers req/gnt/rvalid and each test task drives
  the execute inputs and checks results against the model's bytes
*/

`timescale 1ns/1ns

module lsu_tb import lsu_pkg::*;;

  localparam int TIMEOUT = 2000;  // six tests of up to about 150 cycles each plus margin

  logic              clk;
  logic              rst_n;
  logic              data_req_ex_i, data_we_ex_i, data_sign_ext_ex_i;
  data_type_t        data_type_ex_i;
  logic [DATA_W-1:0] data_wdata_ex_i;
  byte_off_t         data_reg_offset_ex_i;
  logic [ADDR_W-1:0] operand_a_ex_i, operand_b_ex_i;
  logic              addr_useincr_ex_i, data_misaligned_ex_i, ex_valid_i;
  logic [DATA_W-1:0] data_rdata_ex_o;
  logic              data_misaligned_o, lsu_ready_ex_o, lsu_ready_wb_o;
  logic              data_req_o, data_we_o;
  logic [ADDR_W-1:0] data_addr_o;
  logic [BE_W-1:0]   data_be_o;
  logic [DATA_W-1:0] data_wdata_o;
  logic              data_gnt_i, data_rvalid_i;
  logic [DATA_W-1:0] data_rdata_i;

  logic [31:0] mem [16];           // memory model of 64 bytes
  logic [31:0] gnt_addr;           // request seen at the last grant
  logic [3:0]  gnt_be;
  logic        gnt_we, gnt_mis;
  string       cur_test;
  int          errors, checks, tests_run, tests_failed, err_at_start, cycles;
  integer      seed;

  lsu_top i_lsu_top (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic next_cycle;
    @(posedge clk);
    #1;  // inputs change just after the edge
  endtask

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    err_at_start = errors;
    tests_run++;
  endtask

  task automatic end_test;
    if (errors == err_at_start)
      $display("%-18s passed", cur_test);
    else
    begin
      $display("%-18s failed with %0d errors", cur_test, errors - err_at_start);
      tests_failed++;
    end
  endtask

  function automatic logic [7:0] mem_byte(input logic [31:0] a);
    return mem[a[5:2]][{a[1:0], 3'b000} +: 8];
  endfunction

  // little-endian word starting at any byte address
  function automatic logic [31:0] le_word(input logic [31:0] a);
    return {mem_byte(a + 32'd3), mem_byte(a + 32'd2), mem_byte(a + 32'd1), mem_byte(a)};
  endfunction

  function automatic logic [31:0] extend(input logic [31:0] raw, input int nbytes,
                                         input logic sgn);
    logic [31:0] r;
    if (nbytes == 1)
      r = {{24{sgn & raw[7]}}, raw[7:0]};
    else if (nbytes == 2)
      r = {{16{sgn & raw[15]}}, raw[15:0]};
    else
      r = raw;
    return r;
  endfunction

  task automatic drive_ex(input logic req, input logic we, input data_type_t ty,
                          input logic [31:0] wd, input byte_off_t roff, input logic sgn,
                          input logic [31:0] a, input logic [31:0] b, input logic incr,
                          input logic mis);
    data_req_ex_i        = req;
    data_we_ex_i         = we;
    data_type_ex_i       = ty;
    data_wdata_ex_i      = wd;
    data_reg_offset_ex_i = roff;
    data_sign_ext_ex_i   = sgn;
    operand_a_ex_i       = a;
    operand_b_ex_i       = b;
    addr_useincr_ex_i    = incr;
    data_misaligned_ex_i = mis;
  endtask

  task automatic idle_ex;
    data_req_ex_i        = 1'b0;
    data_we_ex_i         = 1'b0;
    data_misaligned_ex_i = 1'b0;
  endtask

  //////////////////////////////
  // memory model
  //////////////////////////////

  // waits for a request and withholds grant for hold cycles before accepting it
  task automatic grant_request(input int hold);
    int i;
    @(negedge clk);
    while (data_req_o !== 1'b1)
    begin
      next_cycle();
      @(negedge clk);
    end
    check("ready_ex before grant", 32'd0, 32'(lsu_ready_ex_o));
    for (i = 0; i < hold; i++)
    begin
      next_cycle();
      @(negedge clk);
      check("req without grant", 32'd1, 32'(data_req_o));
      check("ready_ex without grant", 32'd0, 32'(lsu_ready_ex_o));
    end
    next_cycle();
    data_gnt_i = 1'b1;
    @(negedge clk);
    check("req at grant", 32'd1, 32'(data_req_o));
    check("ready_ex at grant", 32'd1, 32'(lsu_ready_ex_o));
    gnt_addr = data_addr_o;
    gnt_be   = data_be_o;
    gnt_we   = data_we_o;
    gnt_mis  = data_misaligned_o;
    if (data_we_o)
      for (i = 0; i < 4; i++)
        if (data_be_o[i])
          mem[data_addr_o[5:2]][8*i +: 8] = data_wdata_o[8*i +: 8];  // write by lane
    next_cycle();
    data_gnt_i = 1'b0;
  endtask

  // rvalid lat cycles after the grant with the result sampled mid-cycle
  task automatic return_response(input int lat, input bit check_wb, output logic [31:0] res);
    int i;
    for (i = 1; i < lat; i++)
    begin
      @(negedge clk);
      if (check_wb)
        check("ready_wb while waiting", 32'd0, 32'(lsu_ready_wb_o));
      next_cycle();
    end
    data_rvalid_i = 1'b1;
    data_rdata_i  = gnt_we ? 32'd0 : mem[gnt_addr[5:2]];  // whole word since memory ignores the offset
    @(negedge clk);
    res = data_rdata_ex_o;
    next_cycle();
    data_rvalid_i = 1'b0;
    data_rdata_i  = 32'hdead_beef;  // junk outside rvalid
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic aligned_word;
    logic [31:0] res;
    start_test("aligned_word");
    @(negedge clk);
    check("ready_ex after reset", 32'd1, 32'(lsu_ready_ex_o));
    check("ready_wb after reset", 32'd1, 32'(lsu_ready_wb_o));
    check("req after reset", 32'd0, 32'(data_req_o));
    check("result after reset", 32'd0, data_rdata_ex_o);
    next_cycle();
    drive_ex(1'b1, 1'b1, TYPE_WORD, 32'h1234_5678, 2'd0, 1'b0, 32'd8, 32'd12, 1'b1, 1'b0);
    grant_request(0);
    check("store addr", 32'd20, gnt_addr);  // a + b
    check("store be", 32'h0000_000f, 32'(gnt_be));
    check("memory word", 32'h1234_5678, mem[5]);
    idle_ex();
    return_response(2, 1'b1, res);
    // b is ignored when the increment is off
    drive_ex(1'b1, 1'b0, TYPE_WORD, 32'd0, 2'd0, 1'b0, 32'd20, 32'd99, 1'b0, 1'b0);
    grant_request(0);
    idle_ex();
    return_response(3, 1'b1, res);
    check("load data", 32'h1234_5678, res);
    @(negedge clk);
    check("held result", 32'h1234_5678, data_rdata_ex_o);
    next_cycle();
    end_test();
  endtask

  task automatic store_lanes;
    int sz;
    int off;
    int roff;
    int j;
    logic [31:0] a;
    logic [31:0] wd;
    logic [31:0] res;
    logic [3:0]  be_exp;
    data_type_t  ty;
    start_test("store_lanes");
    for (sz = 1; sz <= 2; sz++)
      for (off = 0; off < 4; off++)
      begin
        ty     = (sz == 1) ? TYPE_BYTE : TYPE_HALF;
        roff   = (2 * off) % 4;  // source lane never matches the memory lane except once
        a      = 32'd32 + off;
        wd     = 32'h8a9b_acbd + off;
        for (j = 0; j < 4; j++)
          be_exp[j] = (j >= off) && (j < off + sz);  // lanes covered in this word
        drive_ex(1'b1, 1'b1, ty, wd, byte_off_t'(roff), 1'b0, a, 32'd0, 1'b0, 1'b0);
        grant_request(0);
        check("be", 32'(be_exp), 32'(gnt_be));
        if (sz == 2 && off == 3)
        begin
          // halfword spills into lane 0 of the next word
          drive_ex(1'b1, 1'b1, ty, wd, byte_off_t'(roff), 1'b0, a, 32'd4, 1'b1, 1'b1);
          return_response(1, 1'b0, res);
          grant_request(0);
          check("be second part", 32'd1, 32'(gnt_be));
        end
        idle_ex();
        return_response(1, 1'b0, res);
        for (j = 0; j < sz; j++)
          check("memory byte", 32'(wd[8*((roff + j) % 4) +: 8]), 32'(mem_byte(a + j)));
      end
    end_test();
  endtask

  task automatic load_lanes;
    int base;
    int sz;
    int off;
    int sg;
    logic [31:0] a;
    logic [31:0] res;
    data_type_t  ty;
    start_test("load_lanes");
    for (base = 4; base <= 8; base += 4)   // word 1 has mixed signs and word 2 is all negative
      for (sz = 1; sz <= 2; sz++)
        for (off = 0; off < 5 - sz; off++)   // halfword at offset 3 is a split access
          for (sg = 0; sg < 2; sg++)
          begin
            ty = (sz == 1) ? TYPE_BYTE : TYPE_HALF;
            a  = 32'(base + off);
            drive_ex(1'b1, 1'b0, ty, 32'd0, 2'd0, 1'(sg), a, 32'd0, 1'b0, 1'b0);
            grant_request(0);
            idle_ex();
            return_response(1 + off, 1'b1, res);
            check("load data", extend(le_word(a), sz, 1'(sg)), res);
          end
    end_test();
  endtask

  task automatic split_load;
    int n;
    logic [31:0] a;
    logic [31:0] res;
    data_type_t  ty;
    start_test("split_load");
    for (n = 0; n < 4; n++)
    begin
      ty = (n < 3) ? TYPE_WORD : TYPE_HALF;
      a  = 32'd40 + ((n < 3) ? n + 1 : 3);   // word at offsets 1 to 3 and then a halfword at 3
      drive_ex(1'b1, 1'b0, ty, 32'd0, 2'd0, 1'b1, a, 32'd4, 1'b0, 1'b0);
      grant_request(0);
      check("misaligned first part", 32'd1, 32'(gnt_mis));
      drive_ex(1'b1, 1'b0, ty, 32'd0, 2'd0, 1'b1, a, 32'd4, 1'b1, 1'b1);  // part two at a + 4
      @(negedge clk);
      check("req while part one pending", 32'd0, 32'(data_req_o));
      check("ready_ex while part one pending", 32'd0, 32'(lsu_ready_ex_o));
      next_cycle();
      return_response(1, 1'b0, res);
      grant_request(1);
      check("misaligned second part", 32'd0, 32'(gnt_mis));
      check("second part addr", a + 32'd4, gnt_addr);
      idle_ex();
      return_response(2, 1'b0, res);
      check("load data", extend(le_word(a), (n < 3) ? 4 : 2, 1'b1), res);
    end
    end_test();
  endtask

  task automatic grant_backpressure;
    int n;
    int hold;
    int lat;
    logic [31:0] a;
    logic [31:0] wd;
    logic [31:0] res;
    start_test("grant_backpressure");
    for (n = 0; n < 4; n++)
    begin
      wd   = $random(seed);
      hold = $unsigned($random(seed)) % 5;
      lat  = 1 + $unsigned($random(seed)) % 4;
      a    = 32'd48 + 4 * n;
      drive_ex(1'b1, 1'b1, TYPE_WORD, wd, 2'd0, 1'b0, a, 32'd0, 1'b0, 1'b0);
      grant_request(hold);
      idle_ex();
      return_response(lat, 1'b1, res);
      drive_ex(1'b1, 1'b0, TYPE_WORD, 32'd0, 2'd0, 1'b0, a, 32'd0, 1'b0, 1'b0);
      grant_request(hold + 1);
      idle_ex();
      return_response(lat, 1'b1, res);
      check("load data", wd, res);
    end
    end_test();
  endtask

  task automatic exec_stall;
    int i;
    logic [31:0] res;
    start_test("exec_stall");
    ex_valid_i = 1'b0;  // execute stalled when the grant comes
    drive_ex(1'b1, 1'b0, TYPE_WORD, 32'd0, 2'd0, 1'b0, 32'd0, 32'd0, 1'b0, 1'b0);
    grant_request(0);
    drive_ex(1'b1, 1'b0, TYPE_WORD, 32'd0, 2'd0, 1'b0, 32'd4, 32'd0, 1'b0, 1'b0);
    return_response(2, 1'b0, res);
    check("stalled load data", le_word(32'd0), res);
    for (i = 0; i < 3; i++)
    begin
      @(negedge clk);
      check("req while stalled", 32'd0, 32'(data_req_o));
      next_cycle();
    end
    ex_valid_i = 1'b1;
    grant_request(0);  // request only after the stall clears
    idle_ex();
    return_response(3, 1'b1, res);
    check("load data", le_word(32'd4), res);
    end_test();
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    int i;
    rst_n         = 1'b0;
    ex_valid_i    = 1'b1;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = 32'd0;
    drive_ex(1'b0, 1'b0, TYPE_WORD, 32'd0, 2'd0, 1'b0, 32'd0, 32'd0, 1'b0, 1'b0);
    seed         = 43517;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (i = 0; i < 64; i++)
      mem[i/4][8*(i%4) +: 8] = 8'(i * 37 + 90);  // each byte a function of its address
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();
    aligned_word();
    store_lanes();
    load_lanes();
    split_load();
    grant_backpressure();
    exec_stall();
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // hang guard
  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== all.f ====
verilog/lsu_pkg.sv
verilog/lsu_addr_gen.sv
verilog/lsu_store_align.sv
verilog/lsu_load_align.sv
verilog/lsu_mem_ctrl.sv
verilog/lsu_top.sv
bench/lsu_tb.sv

// ==== Makefile ====
SIM    = verilator
FLAGS  = --binary --timing --assert --timescale 1ns/1ns
TOP    = lsu_tb
FLIST  = all.f
OBJDIR = obj_dir
PASS   = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

# output is shown, status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJDIR)
